//--- design/pvr_defs.svh
`ifndef PVR_DEFS_SVH
`define PVR_DEFS_SVH

// constant words returned by the read mux
`define PVR_ID_VALUE       32'h17FD11DB // device id
`define PVR_REVISION_VALUE 32'h00000011 // core revision

// read-only offsets, writes here are dropped
`define PVR_ID_ADDR       16'h0000
`define PVR_REVISION_ADDR 16'h0004

// register map, 0x000..0x3fc split into equal banks
`define PVR_NUM_BANKS  4
`define PVR_BANK_WORDS 64
`define PVR_REG_LAST   16'h03FC // last mapped register word

// bank select sits right above the word index in the byte address
`define PVR_WORD_IDX_LSB  2
`define PVR_WORD_IDX_BITS $clog2(`PVR_BANK_WORDS)
`define PVR_BANK_SEL_LSB  (`PVR_WORD_IDX_LSB + `PVR_WORD_IDX_BITS)
`define PVR_BANK_SEL_BITS $clog2(`PVR_NUM_BANKS)

// palette ram region 0x1000..0x1fff
`define PVR_PAL_BASE  16'h1000
`define PVR_PAL_WORDS 4096

// ta command fifo
`define PVR_TA_FIFO_DEPTH 256

`endif

//--- design/pvr_pkg.sv
package pvr_pkg;

	typedef logic [31:0] pvr_word_t;      // host bus data word
	typedef logic [15:0] pvr_addr_t;      // host byte address
	typedef logic [5:0]  bank_word_idx_t; // word inside one 64-word bank
	typedef logic [11:0] pal_idx_t;       // palette entry
	typedef logic [8:0]  fifo_count_t;    // 0..256, one bit wider than the fifo address

	// ta command field, codes 2, 3 and 6 are unused
	typedef enum logic [2:0] {
		TA_END_OF_LIST = 3'd0,
		TA_USER_CLIP   = 3'd1,
		TA_POLYGON     = 3'd4, // polygon or modifier volume
		TA_SPRITE      = 3'd5,
		TA_VERTEX      = 3'd7
	} ta_cmd_op_e;

	// command word as popped from the fifo
	typedef struct packed {
		ta_cmd_op_e  cmd;     // bits 31:29
		logic [28:0] options; // per-command flags
	} ta_cmd_t;

endpackage

//--- design/reg_bank_if.sv
`timescale 1ns/10ps
`include "pvr_defs.svh"

interface reg_bank_if;

	logic                               wr_en;    // one-cycle write strobe
	logic [`PVR_WORD_IDX_BITS-1:0]      word_idx; // selects both write target and rdata
	logic [31:0]                        wdata;    // host write data
	logic [31:0]                        rdata;    // word at word_idx, combinational

	modport decode (
		output wr_en,
		output word_idx,
		output wdata
	);

	modport bank (
		input  wr_en,
		input  word_idx,
		input  wdata,
		output rdata
	);

	modport reader (
		input  rdata
	);

endinterface

//--- design/pvr_bus_decode.sv
`timescale 1ns/10ps
`include "pvr_defs.svh"

module pvr_bus_decode
	import pvr_pkg::*;
(
	input  logic       pvr_reg_cs_i,
	input  logic       pvr_wr_i,
	input  pvr_addr_t  pvr_addr_i,
	input  pvr_word_t  pvr_din_i,
	reg_bank_if.decode bank_o [`PVR_NUM_BANKS],
	output logic       pal_we_o,
	output pal_idx_t   pal_idx_o,
	output pvr_word_t  pal_wdata_o
);

	pvr_addr_t                      addr_w;   // byte address with the byte lane dropped
	logic [`PVR_BANK_SEL_BITS-1:0]  bank_sel;
	bank_word_idx_t                 word_idx;
	logic                           host_wr;  // chip-selected write this cycle
	logic                           ro_hit;   // id or revision word
	logic                           reg_hit;  // inside 0x000..0x3fc
	logic                           pal_hit;  // inside palette window
	logic                           reg_wr;
	logic [`PVR_NUM_BANKS-1:0]      bank_we;

	assign addr_w   = {pvr_addr_i[15:2], 2'b00};
	assign bank_sel = pvr_addr_i[`PVR_BANK_SEL_LSB +: `PVR_BANK_SEL_BITS];
	assign word_idx = pvr_addr_i[`PVR_WORD_IDX_LSB +: `PVR_WORD_IDX_BITS];
	assign host_wr  = pvr_reg_cs_i && pvr_wr_i;

	assign ro_hit  = (addr_w == `PVR_ID_ADDR) || (addr_w == `PVR_REVISION_ADDR);
	assign reg_hit = (addr_w <= `PVR_REG_LAST);
	assign pal_hit = ({pvr_addr_i[15:12], 12'h000} == `PVR_PAL_BASE);

	assign reg_wr = host_wr && reg_hit && !ro_hit; // id words keep their constants

	// every bank sees the same index and data with a private strobe
	for (genvar b = 0; b < `PVR_NUM_BANKS; b++) begin : g_bank
		assign bank_we[b]         = reg_wr && (bank_sel == (`PVR_BANK_SEL_BITS)'(b));
		assign bank_o[b].wr_en    = bank_we[b];
		assign bank_o[b].word_idx = word_idx; // also the read select on every cycle
		assign bank_o[b].wdata    = pvr_din_i;
	end

	// palette index keeps the byte offset bits
	assign pal_we_o    = host_wr && pal_hit;
	assign pal_idx_o   = pvr_addr_i[11:0];
	assign pal_wdata_o = pvr_din_i;

	// strobes of all banks together
	always_comb begin
		assert ($onehot0(bank_we))
			else $error("bank write strobes not one-hot: %b", bank_we);
	end

endmodule

//--- design/pvr_reg_bank.sv
`timescale 1ns/10ps
`include "pvr_defs.svh"

module pvr_reg_bank
	import pvr_pkg::*;
(
	input  logic     clock,
	input  logic     reset_n,
	reg_bank_if.bank bus
);

	pvr_word_t regs [`PVR_BANK_WORDS]; // control, ta and fog table words

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < `PVR_BANK_WORDS; i++) begin
				regs[i] <= '0; // whole map comes up zero
			end
		end else if (bus.wr_en) begin
			regs[bus.word_idx] <= bus.wdata;
		end
	end

	assign bus.rdata = regs[bus.word_idx]; // same-cycle read for the host mux

	// index comes from the decoder, an X here would corrupt a random word
	a_idx_known: assert property (
		@(posedge clock) disable iff (!reset_n)
		bus.wr_en |-> !$isunknown(bus.word_idx)
	) else $error("bank write with unknown word index");

endmodule

//--- design/pvr_read_mux.sv
`timescale 1ns/10ps
`include "pvr_defs.svh"

module pvr_read_mux
	import pvr_pkg::*;
(
	input  pvr_addr_t  pvr_addr_i,
	reg_bank_if.reader bank_i [`PVR_NUM_BANKS],
	input  pvr_word_t  pal_rdata_i,
	output pvr_word_t  pvr_dout_o
);

	pvr_addr_t                     addr_w;
	logic [`PVR_BANK_SEL_BITS-1:0] bank_sel;
	pvr_word_t                     bank_rdata [`PVR_NUM_BANKS]; // flattened for a dynamic index

	assign addr_w   = {pvr_addr_i[15:2], 2'b00};
	assign bank_sel = pvr_addr_i[`PVR_BANK_SEL_LSB +: `PVR_BANK_SEL_BITS];

	// interface arrays only take constant indices
	for (genvar b = 0; b < `PVR_NUM_BANKS; b++) begin : g_bank
		assign bank_rdata[b] = bank_i[b].rdata;
	end

	always_comb begin
		if (addr_w == `PVR_ID_ADDR) begin
			pvr_dout_o = `PVR_ID_VALUE; // shadows bank 0 word 0
		end else if (addr_w == `PVR_REVISION_ADDR) begin
			pvr_dout_o = `PVR_REVISION_VALUE;
		end else if (addr_w <= `PVR_REG_LAST) begin
			pvr_dout_o = bank_rdata[bank_sel];
		end else if ({pvr_addr_i[15:12], 12'h000} == `PVR_PAL_BASE) begin
			pvr_dout_o = pal_rdata_i;
		end else begin
			pvr_dout_o = '0; // unmapped, incl. old object list pointer window
		end
	end

endmodule

//--- design/pal_ram.sv
`timescale 1ns/10ps
`include "pvr_defs.svh"

module pal_ram
	import pvr_pkg::*;
(
	input  logic      clock,
	input  logic      pal_we_i,
	input  pal_idx_t  pal_idx_i,   // shared by write and read
	input  pvr_word_t pal_wdata_i,
	output pvr_word_t pal_rdata_o
);

	pvr_word_t mem [`PVR_PAL_WORDS];

	always_ff @(posedge clock) begin
		if (pal_we_i) begin
			mem[pal_idx_i] <= pal_wdata_i;
		end
	end

	// async read so the host sees the entry in the address cycle
	assign pal_rdata_o = mem[pal_idx_i];

endmodule

//--- design/ta_fifo.sv
`timescale 1ns/10ps
`include "pvr_defs.svh"

module ta_fifo
	import pvr_pkg::*;
(
	input  logic        clock,
	input  logic        reset_n,
	input  logic        wr_i,
	input  pvr_word_t   din_i,
	input  logic        rd_i,
	output ta_cmd_t     dout_o,  // oldest word one cycle after a pop
	output logic        full_o,
	output logic        empty_o,
	output fifo_count_t words_o
);

	localparam int AW = $clog2(`PVR_TA_FIFO_DEPTH);

	pvr_word_t     mem [`PVR_TA_FIFO_DEPTH];
	logic [AW:0]   wptr;    // extra msb tells wrap parity
	logic [AW:0]   rptr;
	logic          push;
	logic          pop;

	assign push = wr_i && !full_o; // dropped when full
	assign pop  = rd_i && !empty_o; // ignored when empty

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	// storage and output word
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wptr[AW-1:0]] <= din_i;
		end
		if (pop) begin
			dout_o <= ta_cmd_t'(mem[rptr[AW-1:0]]); // holds until next pop
		end
	end

	assign empty_o = (wptr == rptr);
	assign full_o  = (wptr[AW-1:0] == rptr[AW-1:0]) && (wptr[AW] != rptr[AW]);
	assign words_o = wptr - rptr; // reaches 256 when full

	a_count_max: assert property (
		@(posedge clock) disable iff (!reset_n)
		words_o <= fifo_count_t'(`PVR_TA_FIFO_DEPTH)
	) else $error("fifo count above depth: %0d", words_o);

	// a push on a full fifo with no pop leaves it full at depth
	a_no_push_full: assert property (
		@(posedge clock) disable iff (!reset_n)
		(wr_i && full_o && !rd_i)
			|=> (full_o && words_o == fifo_count_t'(`PVR_TA_FIFO_DEPTH))
	) else $error("push while full changed the fifo fill state");

endmodule

//--- design/pvr_core.sv
`timescale 1ns/10ps
`include "pvr_defs.svh"

module pvr_core
	import pvr_pkg::*;
(
	input  logic        clock,
	input  logic        reset_n,

	// host register bus
	input  logic        pvr_reg_cs_i,
	input  pvr_addr_t   pvr_addr_i,
	input  pvr_word_t   pvr_din_i,
	input  logic        pvr_wr_i,
	output pvr_word_t   pvr_dout_o,   // combinational from pvr_addr_i

	// ta command fifo
	input  logic        ta_fifo_wr_i,
	input  logic        ta_fifo_rd_i,
	output ta_cmd_t     ta_cmd_o,
	output logic        ta_fifo_full_o,
	output logic        ta_fifo_empty_o,
	output fifo_count_t ta_fifo_words_o
);

	reg_bank_if bank_if [`PVR_NUM_BANKS] (); // one link per bank

	logic      pal_we;
	pal_idx_t  pal_idx;
	pvr_word_t pal_wdata;
	pvr_word_t pal_rdata;

	pvr_bus_decode u_decode (
		.pvr_reg_cs_i (pvr_reg_cs_i),
		.pvr_wr_i     (pvr_wr_i),
		.pvr_addr_i   (pvr_addr_i),
		.pvr_din_i    (pvr_din_i),
		.bank_o       (bank_if),
		.pal_we_o     (pal_we),
		.pal_idx_o    (pal_idx),
		.pal_wdata_o  (pal_wdata)
	);

	// four 64-word slices of 0x000..0x3fc
	for (genvar g = 0; g < `PVR_NUM_BANKS; g++) begin : g_bank
		pvr_reg_bank u_bank (
			.clock   (clock),
			.reset_n (reset_n),
			.bus     (bank_if[g])
		);
	end

	pvr_read_mux u_read_mux (
		.pvr_addr_i  (pvr_addr_i),
		.bank_i      (bank_if),
		.pal_rdata_i (pal_rdata),
		.pvr_dout_o  (pvr_dout_o)
	);

	pal_ram u_pal (
		.clock       (clock),
		.pal_we_i    (pal_we),
		.pal_idx_i   (pal_idx),
		.pal_wdata_i (pal_wdata),
		.pal_rdata_o (pal_rdata)
	);

	// commands come straight off the host data bus
	ta_fifo u_ta_fifo (
		.clock   (clock),
		.reset_n (reset_n),
		.wr_i    (ta_fifo_wr_i),
		.din_i   (pvr_din_i),
		.rd_i    (ta_fifo_rd_i),
		.dout_o  (ta_cmd_o),
		.full_o  (ta_fifo_full_o),
		.empty_o (ta_fifo_empty_o),
		.words_o (ta_fifo_words_o)
	);

endmodule

//--- dv/tb_pvr.sv
`timescale 1ns/10ps
`include "pvr_defs.svh"

module tb_pvr
	import pvr_pkg::*;
();

	localparam int RESET_CYCLES = 8;
	localparam int MAP_WORDS    = `PVR_NUM_BANKS * `PVR_BANK_WORDS;
	localparam int N_REG_OPS    = 400;
	localparam int N_BLOCK_OPS  = 120;
	localparam int N_PAL_OPS    = 300;
	localparam int N_FIFO_OPS   = 600;
	localparam int N_OVF_PUSH   = 260;
	// cycle budget of each test section in run order
	localparam int TEST_CYCLES  = (MAP_WORDS + 2) + 2 * N_REG_OPS + 2 * N_BLOCK_OPS
		+ MAP_WORDS + 2 * N_PAL_OPS + (N_FIFO_OPS + 2)
		+ (2 * `PVR_TA_FIFO_DEPTH + N_OVF_PUSH + 8);
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + RESET_CYCLES;

	logic        clock;
	logic        reset_n;
	logic        reg_cs;
	pvr_addr_t   addr;
	pvr_word_t   din;
	logic        wr;
	pvr_word_t   dout;
	logic        fifo_wr;
	logic        fifo_rd;
	ta_cmd_t     ta_cmd;
	logic        fifo_full;
	logic        fifo_empty;
	fifo_count_t fifo_words;

	pvr_word_t   reg_model [MAP_WORDS];      // host view of 0x000..0x3fc
	pvr_word_t   pal_model [`PVR_PAL_WORDS]; // indexed by addr[11:0]
	pvr_addr_t   pal_written [$];            // palette entries that hold known data
	pvr_word_t   fifo_model [$];
	pvr_word_t   last_pop;                   // what ta_cmd should hold
	logic        popped_any;
	logic [31:0] rng_state;
	int          error_count;
	int          cycle_count;

	pvr_core u_dut (
		.clock           (clock),
		.reset_n         (reset_n),
		.pvr_reg_cs_i    (reg_cs),
		.pvr_addr_i      (addr),
		.pvr_din_i       (din),
		.pvr_wr_i        (wr),
		.pvr_dout_o      (dout),
		.ta_fifo_wr_i    (fifo_wr),
		.ta_fifo_rd_i    (fifo_rd),
		.ta_cmd_o        (ta_cmd),
		.ta_fifo_full_o  (fifo_full),
		.ta_fifo_empty_o (fifo_empty),
		.ta_fifo_words_o (fifo_words)
	);

	always #20 clock = ~clock; // 40 ns period

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13); // xorshift32
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %0d ns: %s, got %h, expected %h",
				$time, what, actual, expected);
		end
	endtask

	function automatic pvr_word_t expected_read(input pvr_addr_t a);
		if (a == `PVR_ID_ADDR) return `PVR_ID_VALUE;
		if (a == `PVR_REVISION_ADDR) return `PVR_REVISION_VALUE;
		if (a <= `PVR_REG_LAST) return reg_model[a[9:2]];
		if (a[15:12] == 4'h1) return pal_model[a[11:0]]; // palette window
		return '0;
	endfunction

	task automatic model_write(input logic cs, input pvr_addr_t a, input pvr_word_t d);
		if (!cs || a == `PVR_ID_ADDR || a == `PVR_REVISION_ADDR) return; // nothing lands
		if (a <= `PVR_REG_LAST) reg_model[a[9:2]] = d;
		else if (a[15:12] == 4'h1) pal_model[a[11:0]] = d;
	endtask

	function automatic pvr_addr_t random_unmapped_addr();
		logic [31:0] r;
		pvr_addr_t   a;
		do begin
			r = next_rand();
			a = {r[15:2], 2'b00};
		end while (a <= `PVR_REG_LAST || a[15:12] == 4'h1);
		return a;
	endfunction

	// write strobe lands on the following edge
	task automatic bus_write(input logic cs, input pvr_addr_t a, input pvr_word_t d);
		@(posedge clock);
		reg_cs <= cs;
		wr     <= 1'b1;
		addr   <= a;
		din    <= d;
		model_write(cs, a, d);
	endtask

	task automatic read_and_compare(input pvr_addr_t a, input string what);
		@(posedge clock);
		reg_cs <= 1'b1;
		wr     <= 1'b0;
		addr   <= a;
		@(negedge clock); // combinational dout settled by mid-cycle
		check_value(dout, expected_read(a), $sformatf("%s at %h", what, a));
	endtask

	task automatic check_fifo_state();
		check_value(32'(fifo_words), fifo_model.size(), "fifo count");
		check_value(32'(fifo_empty), 32'(fifo_model.size() == 0), "fifo empty flag");
		check_value(32'(fifo_full), 32'(fifo_model.size() == `PVR_TA_FIFO_DEPTH),
			"fifo full flag");
		if (popped_any) check_value(ta_cmd, last_pop, "popped command");
	endtask

	// checks the state left by the previous step and books this one
	task automatic fifo_step(input logic push, input logic pop, input pvr_word_t data);
		int size_before;
		@(posedge clock);
		fifo_wr <= push;
		fifo_rd <= pop;
		din     <= data;
		@(negedge clock);
		check_fifo_state();
		size_before = fifo_model.size();
		if (pop && size_before > 0) begin
			last_pop   = fifo_model.pop_front();
			popped_any = 1'b1;
		end
		if (push && size_before < `PVR_TA_FIFO_DEPTH) fifo_model.push_back(data);
	endtask

	initial begin
		logic [31:0] r;
		pvr_word_t   d;
		pvr_addr_t   a;
		clock       = 1'b0;
		reset_n     = 1'b0;
		reg_cs      = 1'b0;
		wr          = 1'b0;
		addr        = '0;
		din         = '0;
		fifo_wr     = 1'b0;
		fifo_rd     = 1'b0;
		rng_state   = 32'd95;
		error_count = 0;
		cycle_count = 0;
		popped_any  = 1'b0;
		last_pop    = '0;
		foreach (reg_model[i]) reg_model[i] = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset_n <= 1'b1;

		@(negedge clock);
		check_fifo_state(); // fresh fifo after reset
		for (int i = 0; i < MAP_WORDS; i++) begin
			read_and_compare(pvr_addr_t'(i * 4), "reset value");
		end

		for (int i = 0; i < N_REG_OPS; i++) begin
			r = next_rand();
			d = next_rand();
			a = {6'd0, r[9:2], 2'b00};
			bus_write(1'b1, a, d);
			if (r[16]) read_and_compare(a, "register readback");
			else read_and_compare({6'd0, r[25:18], 2'b00}, "register read");
		end

		for (int i = 0; i < N_BLOCK_OPS; i++) begin
			r = next_rand();
			d = next_rand();
			// 0 read-only words, 1 register with chip select low, else unmapped
			case (r[1:0])
				2'd0: a = r[2] ? `PVR_REVISION_ADDR : `PVR_ID_ADDR;
				2'd1: a = {6'd0, r[9:2], 2'b00};
				default: a = random_unmapped_addr();
			endcase
			bus_write(r[1:0] != 2'd1, a, d); // case 1 writes with chip select low
			read_and_compare(a, "blocked write");
		end
		for (int i = 0; i < MAP_WORDS; i++) begin
			read_and_compare(pvr_addr_t'(i * 4), "register sweep");
		end

		for (int i = 0; i < N_PAL_OPS; i++) begin
			r = next_rand();
			d = next_rand();
			if (r[0] || pal_written.size() == 0) begin
				a = {4'h1, r[11:2], 2'b00};
				bus_write(1'b1, a, d);
				pal_written.push_back(a);
				read_and_compare(a, "palette readback");
			end else begin
				a = pal_written[r[31:8] % pal_written.size()];
				read_and_compare(a, "palette read");
			end
		end
		@(posedge clock);
		reg_cs <= 1'b0;

		for (int i = 0; i < N_FIFO_OPS; i++) begin
			r = next_rand();
			fifo_step(r[0], r[1], next_rand());
		end
		fifo_step(1'b0, 1'b0, '0);

		while (fifo_model.size() > 0) fifo_step(1'b0, 1'b1, '0); // drain first
		fifo_step(1'b0, 1'b0, '0);
		for (int i = 0; i < N_OVF_PUSH; i++) fifo_step(1'b1, 1'b0, next_rand());
		fifo_step(1'b0, 1'b0, '0);
		check_value(32'(fifo_words), `PVR_TA_FIFO_DEPTH, "count after overflow");
		check_value(32'(fifo_full), 32'd1, "full after overflow");
		for (int i = 0; i < `PVR_TA_FIFO_DEPTH; i++) fifo_step(1'b0, 1'b1, '0);
		fifo_step(1'b0, 1'b1, '0); // pop on empty is ignored
		fifo_step(1'b0, 1'b0, '0);
		check_value(32'(fifo_empty), 32'd1, "empty after drain");

		$display("errors: %0d", error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+design
design/pvr_pkg.sv
design/reg_bank_if.sv
design/pvr_bus_decode.sv
design/pvr_reg_bank.sv
design/pvr_read_mux.sv
design/pal_ram.sv
design/ta_fifo.sv
design/pvr_core.sv
dv/tb_pvr.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_pvr and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module tb_pvr -Mdir obj_dir
	./obj_dir/Vtb_pvr 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
